//--- Makefile
# Verilator flow for the integer execute path

VERILATOR ?= verilator
TOP       ?= tb_int_exu
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The status is decided by the search for the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- alu.sv
`default_nettype none

module alu
  import exu_pkg::*;
#(
  parameter bit has_branch = 1'b1
) (
  input  fu_data_t        fu_data_i,
  output logic [XLEN-1:0] result_o,
  output logic            branch_res_o
);

  localparam int unsigned SHW   = $clog2(XLEN);
  localparam int unsigned CNT_W = SHW + 1;

  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] value);
    logic [XLEN-1:0] rev;
    for (int i = 0; i < XLEN; i++) begin
      rev[i] = value[XLEN-1-i];
    end
    return rev;
  endfunction

  logic [XLEN-1:0] operand_a_rev;

  assign operand_a_rev = bit_rev(fu_data_i.operand_a);

  // ------------------------------------------------
  // Adder
  // ------------------------------------------------
  logic            adder_negate;
  logic [XLEN:0]   adder_in_a;
  logic [XLEN:0]   operand_b_neg;
  logic [XLEN:0]   adder_sum;
  logic [XLEN-1:0] adder_result;
  logic            adder_zero;

  assign adder_negate  = fu_data_i.operation inside {SUB, EQ, NE, ANDN, ORN, XNOR};
  // Low bit of a is 1 so that the inverted b picks up its +1 carry
  assign adder_in_a    = {fu_data_i.operand_a, 1'b1};
  assign operand_b_neg = {fu_data_i.operand_b, 1'b0} ^ {(XLEN+1){adder_negate}};
  assign adder_sum     = adder_in_a + operand_b_neg;
  assign adder_result  = adder_sum[XLEN:1];
  assign adder_zero    = ~|adder_result;

  // ------------------------------------------------
  // Comparator
  // ------------------------------------------------
  logic cmp_signed;
  logic less;

  assign cmp_signed = fu_data_i.operation inside {SLTS, LTS, GES, MIN, MAX};
  assign less = $signed({cmp_signed & fu_data_i.operand_a[XLEN-1], fu_data_i.operand_a}) <
                $signed({cmp_signed & fu_data_i.operand_b[XLEN-1], fu_data_i.operand_b});

  if (has_branch) begin : gen_branch
    always_comb begin
      unique case (fu_data_i.operation)
        EQ:       branch_res_o = adder_zero;
        NE:       branch_res_o = ~adder_zero;
        LTS, LTU: branch_res_o = less;
        GES, GEU: branch_res_o = ~less;
        default:  branch_res_o = 1'b0;
      endcase
    end
  end else begin : gen_no_branch
    assign branch_res_o = 1'b0;
  end

  // ------------------------------------------------
  // Shifter
  // ------------------------------------------------
  logic            shift_left;
  logic            shift_arith;
  logic [SHW-1:0]  shift_amt;
  logic [XLEN-1:0] shift_op_a;
  logic [XLEN:0]   shift_op_ext;
  logic [XLEN:0]   shift_right_result;
  logic [XLEN-1:0] shift_result;

  assign shift_left  = (fu_data_i.operation == SLL);
  assign shift_arith = (fu_data_i.operation == SRA);
  assign shift_amt   = fu_data_i.operand_b[SHW-1:0];

  // Left shift is a right shift of the reversed operand
  assign shift_op_a         = shift_left ? operand_a_rev : fu_data_i.operand_a;
  assign shift_op_ext       = {shift_arith & shift_op_a[XLEN-1], shift_op_a};
  assign shift_right_result = $unsigned($signed(shift_op_ext) >>> shift_amt);
  assign shift_result       = shift_left ? bit_rev(shift_right_result[XLEN-1:0])
                                         : shift_right_result[XLEN-1:0];

  // ------------------------------------------------
  // Zbb logic
  // ------------------------------------------------
  logic [XLEN-1:0]  lz_in;
  logic [CNT_W-1:0] lz_count;
  logic             lz_found;
  logic [CNT_W-1:0] cpop;
  logic [XLEN-1:0]  rol_result;
  logic [XLEN-1:0]  ror_result;
  logic [XLEN-1:0]  orcb_result;
  logic [XLEN-1:0]  rev8_result;

  // CTZ counts leading zeros of the reversed operand
  assign lz_in = (fu_data_i.operation == CTZ) ? operand_a_rev : fu_data_i.operand_a;

  always_comb begin
    lz_count = '0;
    lz_found = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (!lz_found) begin
        if (lz_in[i]) begin
          lz_found = 1'b1;
        end else begin
          lz_count = lz_count + 1'b1;
        end
      end
    end
  end

  always_comb begin
    cpop = '0;
    for (int i = 0; i < XLEN; i++) begin
      cpop = cpop + {{(CNT_W-1){1'b0}}, fu_data_i.operand_a[i]};
    end
  end

  // Shift by XLEN gives zero, so amount 0 rotates cleanly
  assign rol_result = (fu_data_i.operand_a << shift_amt) |
                      (fu_data_i.operand_a >> (XLEN - shift_amt));
  assign ror_result = (fu_data_i.operand_a >> shift_amt) |
                      (fu_data_i.operand_a << (XLEN - shift_amt));

  for (genvar b = 0; b < XLEN / 8; b++) begin : gen_bytes
    assign orcb_result[8*b +: 8] = {8{|fu_data_i.operand_a[8*b +: 8]}};
    assign rev8_result[8*b +: 8] = fu_data_i.operand_a[XLEN-8-8*b +: 8];
  end

  // ------------------------------------------------
  // Result mux
  // ------------------------------------------------
  always_comb begin
    result_o = '0;
    unique case (fu_data_i.operation)
      ADD, SUB:     result_o = adder_result;
      XORL, XNOR:   result_o = fu_data_i.operand_a ^ operand_b_neg[XLEN:1];
      ORL, ORN:     result_o = fu_data_i.operand_a | operand_b_neg[XLEN:1];
      ANDL, ANDN:   result_o = fu_data_i.operand_a & operand_b_neg[XLEN:1];
      SLL, SRL, SRA: result_o = shift_result;
      SLTS, SLTU:   result_o = {{(XLEN-1){1'b0}}, less};
      MIN, MINU:    result_o = less ? fu_data_i.operand_a : fu_data_i.operand_b;
      MAX, MAXU:    result_o = less ? fu_data_i.operand_b : fu_data_i.operand_a;
      CLZ, CTZ:     result_o = {{(XLEN-CNT_W){1'b0}}, lz_count};
      CPOP:         result_o = {{(XLEN-CNT_W){1'b0}}, cpop};
      SEXTB:        result_o = {{(XLEN-8){fu_data_i.operand_a[7]}}, fu_data_i.operand_a[7:0]};
      SEXTH:        result_o = {{(XLEN-16){fu_data_i.operand_a[15]}}, fu_data_i.operand_a[15:0]};
      ROL:          result_o = rol_result;
      ROR:          result_o = ror_result;
      ORCB:         result_o = orcb_result;
      REV8:         result_o = rev8_result;
      // Branch compares leave the result at zero
      default:      result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- exu_decoder.sv
`default_nettype none

module exu_decoder
  import exu_pkg::*;
#(
  parameter bit has_branch = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            valid_i,
  input  logic [31:0]     instr_i,
  input  logic [31:0]     pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  output fu_data_t        fu_data_o
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [4:0]      rs2_field;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_b_type;

  alu_op_e  operation;
  logic     illegal;
  logic     is_branch;
  logic     use_imm;
  logic     use_shamt;
  fu_data_t fu_data_d;

  // Instruction fields
  assign opcode     = opcode_e'(instr_i[6:0]);
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign rs2_field  = instr_i[24:20];
  assign imm_i_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_b_type = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};

  // ------------------------------------------------
  // Operation select
  // ------------------------------------------------
  always_comb begin
    operation = ADD;
    illegal   = 1'b0;
    is_branch = 1'b0;
    use_imm   = 1'b0;
    use_shamt = 1'b0;
    unique case (opcode)
      OP: begin
        unique case ({funct7, funct3})
          {7'b0000000, 3'b000}: operation = ADD;
          {7'b0100000, 3'b000}: operation = SUB;
          {7'b0000000, 3'b001}: operation = SLL;
          {7'b0000000, 3'b010}: operation = SLTS;
          {7'b0000000, 3'b011}: operation = SLTU;
          {7'b0000000, 3'b100}: operation = XORL;
          {7'b0000000, 3'b101}: operation = SRL;
          {7'b0100000, 3'b101}: operation = SRA;
          {7'b0000000, 3'b110}: operation = ORL;
          {7'b0000000, 3'b111}: operation = ANDL;
          {7'b0100000, 3'b111}: operation = ANDN;
          {7'b0100000, 3'b110}: operation = ORN;
          {7'b0100000, 3'b100}: operation = XNOR;
          {7'b0000101, 3'b100}: operation = MIN;
          {7'b0000101, 3'b101}: operation = MINU;
          {7'b0000101, 3'b110}: operation = MAX;
          {7'b0000101, 3'b111}: operation = MAXU;
          {7'b0110000, 3'b001}: operation = ROL;
          {7'b0110000, 3'b101}: operation = ROR;
          default:              illegal   = 1'b1;
        endcase
      end
      OP_IMM: begin
        use_imm = 1'b1;
        unique case (funct3)
          3'b000: operation = ADD;
          3'b010: operation = SLTS;
          3'b011: operation = SLTU;
          3'b100: operation = XORL;
          3'b110: operation = ORL;
          3'b111: operation = ANDL;
          3'b001: begin
            use_shamt = 1'b1;
            if (funct7 == 7'b0000000) begin
              operation = SLL;
            end else if (funct7 == 7'b0110000) begin
              // Unary Zbb ops, selected by the rs2 field
              unique case (rs2_field)
                5'b00000: operation = CLZ;
                5'b00001: operation = CTZ;
                5'b00010: operation = CPOP;
                5'b00100: operation = SEXTB;
                5'b00101: operation = SEXTH;
                default:  illegal   = 1'b1;
              endcase
            end else begin
              illegal = 1'b1;
            end
          end
          3'b101: begin
            use_shamt = 1'b1;
            unique case (funct7)
              7'b0000000: operation = SRL;
              7'b0100000: operation = SRA;
              7'b0110000: operation = ROR;
              7'b0110100: begin
                if (rs2_field == 5'b11000) begin
                  operation = REV8;
                end else begin
                  illegal = 1'b1;
                end
              end
              7'b0010100: begin
                if (rs2_field == 5'b00111) begin
                  operation = ORCB;
                end else begin
                  illegal = 1'b1;
                end
              end
              default:    illegal = 1'b1;
            endcase
          end
          default: illegal = 1'b1;
        endcase
      end
      BRANCH: begin
        if (has_branch) begin
          is_branch = 1'b1;
          unique case (funct3)
            3'b000:  operation = EQ;
            3'b001:  operation = NE;
            3'b100:  operation = LTS;
            3'b101:  operation = GES;
            3'b110:  operation = LTU;
            3'b111:  operation = GEU;
            default: illegal   = 1'b1;
          endcase
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  // Record build, empty when no instruction enters
  always_comb begin
    fu_data_d = '0;
    if (valid_i) begin
      fu_data_d.valid     = 1'b1;
      fu_data_d.illegal   = illegal;
      fu_data_d.is_branch = is_branch & ~illegal;
      fu_data_d.operation = illegal ? ADD : operation;
      fu_data_d.operand_a = rs1_data_i;
      if (use_shamt) begin
        fu_data_d.operand_b = {{(XLEN-5){1'b0}}, rs2_field};
      end else begin
        fu_data_d.operand_b = use_imm ? imm_i_type : rs2_data_i;
      end
      fu_data_d.imm = is_branch ? imm_b_type : imm_i_type;
      fu_data_d.pc  = pc_i;
      // Branches and bad encodings never write a register
      fu_data_d.rd  = (is_branch || illegal) ? 5'd0 : instr_i[11:7];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fu_data_o <= '0;
    end else begin
      fu_data_o <= fu_data_d;
    end
  end

endmodule

`default_nettype wire

//--- exu_pkg.sv
`default_nettype none

package exu_pkg;

  // Data path width
  localparam int unsigned XLEN = 32;

  // Major opcodes handled by the execute path
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    BRANCH = 7'b1100011
  } opcode_e;

  // ------------------------------------------------
  // ALU operations
  // ------------------------------------------------
  typedef enum logic [5:0] {
    // RV32I arithmetic and logic
    ADD, SUB, SLL, SLTS, SLTU, XORL, SRL, SRA, ORL, ANDL,
    // Branch compares
    EQ, NE, LTS, GES, LTU, GEU,
    // Zbb subset
    ANDN, ORN, XNOR,
    MIN, MAX, MINU, MAXU,
    CLZ, CTZ, CPOP,
    SEXTB, SEXTH,
    ROL, ROR,
    ORCB, REV8
  } alu_op_e;

  // ------------------------------------------------
  // Records passed between stages
  // ------------------------------------------------

  // Decoded operation, decoder to ALU and result stage
  typedef struct packed {
    logic            valid;
    logic            illegal;
    logic            is_branch;
    alu_op_e         operation;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] imm;
    logic [31:0]     pc;
    logic [4:0]      rd;
  } fu_data_t;

  // Writeback port
  typedef struct packed {
    logic            valid;
    logic            illegal;
    logic [4:0]      rd;
    logic [XLEN-1:0] result;
  } wb_t;

  // Resolved branch
  typedef struct packed {
    logic        valid;
    logic        taken;
    logic [31:0] target;
  } branch_t;

endpackage

`default_nettype wire

//--- exu_result.sv
`default_nettype none

module exu_result
  import exu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  fu_data_t        fu_data_i,
  input  logic [XLEN-1:0] alu_result_i,
  input  logic            branch_res_i,
  output wb_t             wb_o,
  output branch_t         branch_o
);

  wb_t     wb_d;
  branch_t branch_d;
  logic    branch_valid;
  logic    kill_result;

  // ------------------------------------------------
  // Writeback record
  // ------------------------------------------------

  // Nothing reaches x0, and bad or branch ops carry no data
  assign kill_result = (fu_data_i.rd == 5'd0) || fu_data_i.illegal || fu_data_i.is_branch;

  always_comb begin
    wb_d.valid   = fu_data_i.valid;
    wb_d.illegal = fu_data_i.valid & fu_data_i.illegal;
    wb_d.rd      = fu_data_i.rd;
    wb_d.result  = kill_result ? '0 : alu_result_i;
  end

  // ------------------------------------------------
  // Branch outcome
  // ------------------------------------------------
  assign branch_valid = fu_data_i.valid & fu_data_i.is_branch & ~fu_data_i.illegal;

  always_comb begin
    branch_d = '0;
    if (branch_valid) begin
      branch_d.valid  = 1'b1;
      branch_d.taken  = branch_res_i;
      // Target wraps at 32 bits
      branch_d.target = fu_data_i.pc + fu_data_i.imm;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_o     <= '0;
      branch_o <= '0;
    end else begin
      wb_o     <= wb_d;
      branch_o <= branch_d;
    end
  end

endmodule

`default_nettype wire

//--- int_exu_top.sv
`default_nettype none

module int_exu_top
  import exu_pkg::*;
#(
  parameter bit has_branch = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            valid_i,
  input  logic [31:0]     instr_i,
  input  logic [31:0]     pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  output wb_t             wb_o,
  output branch_t         branch_o
);

  fu_data_t        fu_data;
  logic [XLEN-1:0] alu_result;
  logic            branch_res;

  // Decode stage, one cycle
  exu_decoder #(
    .has_branch(has_branch)
  ) i_decoder (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (valid_i),
    .instr_i   (instr_i),
    .pc_i      (pc_i),
    .rs1_data_i(rs1_data_i),
    .rs2_data_i(rs2_data_i),
    .fu_data_o (fu_data)
  );

  alu #(
    .has_branch(has_branch)
  ) i_alu (
    .fu_data_i   (fu_data),
    .result_o    (alu_result),
    .branch_res_o(branch_res)
  );

  // Result stage, second cycle
  exu_result i_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .fu_data_i   (fu_data),
    .alu_result_i(alu_result),
    .branch_res_i(branch_res),
    .wb_o        (wb_o),
    .branch_o    (branch_o)
  );

endmodule

`default_nettype wire

//--- tb_int_exu.sv
`default_nettype none

module tb_int_exu
  import exu_pkg::*;
();

  localparam int RESET_CYCLES = 4;
  localparam int DRAIN_CYCLES = 8;
  // Reg-reg, immediate, branch, Zbb and illegal groups
  localparam int N_INSTR      = 50 + 35 + 30 + 36 + 10;
  localparam int MAX_CYCLES   = 4 * (N_INSTR + RESET_CYCLES + DRAIN_CYCLES);

  typedef struct packed {
    wb_t         wb;
    branch_t     br;
    logic [31:0] due;
  } exp_t;

  logic            clk_i = 1'b0;
  logic            rst_n_i;
  logic            valid_i;
  logic [31:0]     instr_i;
  logic [31:0]     pc_i;
  logic [XLEN-1:0] rs1_data_i;
  logic [XLEN-1:0] rs2_data_i;
  wb_t             wb;
  branch_t         br;

  exp_t exp_q[$];
  int   cycles = 0;
  int   errors = 0;
  int   seed   = 90;

  int_exu_top #(
    .has_branch(1'b1)
  ) dut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (valid_i),
    .instr_i   (instr_i),
    .pc_i      (pc_i),
    .rs1_data_i(rs1_data_i),
    .rs2_data_i(rs2_data_i),
    .wb_o      (wb),
    .branch_o  (br)
  );

  always #20 clk_i = ~clk_i;

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------
  function automatic logic [31:0] count_lead_zeros(input logic [31:0] v);
    logic [31:0] n;
    logic        found;
    n     = 0;
    found = 1'b0;
    for (int i = 31; i >= 0; i--) begin
      if (v[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n = n + 1;
      end
    end
    return n;
  endfunction

  function automatic logic [31:0] count_trail_zeros(input logic [31:0] v);
    logic [31:0] n;
    logic        found;
    n     = 0;
    found = 1'b0;
    for (int i = 0; i < 32; i++) begin
      if (v[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n = n + 1;
      end
    end
    return n;
  endfunction

  function automatic logic [31:0] pop_count(input logic [31:0] v);
    logic [31:0] n;
    n = 0;
    for (int i = 0; i < 32; i++) begin
      n = n + v[i];
    end
    return n;
  endfunction

  // Positive amount rotates left, bit i lands at i + s
  function automatic logic [31:0] rotate(input logic [31:0] v, input int s);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
      r[(i + s) % 32] = v[i];
    end
    return r;
  endfunction

  function automatic logic [31:0] or_combine(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = (v[8*i +: 8] != 0) ? 8'hff : 8'h00;
    end
    return r;
  endfunction

  function automatic exp_t predict(input logic [31:0] instr, input logic [31:0] pc_v,
                                   input logic [31:0] a, input logic [31:0] b);
    exp_t        e;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  sh;
    logic [31:0] imm;
    logic [31:0] bimm;
    logic [31:0] res;
    logic        ok;
    logic        is_br;
    logic        taken;
    e     = '0;
    f7    = instr[31:25];
    f3    = instr[14:12];
    sh    = instr[24:20];
    imm   = {{20{instr[31]}}, instr[31:20]};
    bimm  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    res   = '0;
    ok    = 1'b1;
    is_br = 1'b0;
    taken = 1'b0;
    case (instr[6:0])
      OP: begin
        case ({f7, f3})
          {7'h00, 3'd0}: res = a + b;
          {7'h20, 3'd0}: res = a - b;
          {7'h00, 3'd1}: res = a << b[4:0];
          {7'h00, 3'd2}: res = {31'b0, $signed(a) < $signed(b)};
          {7'h00, 3'd3}: res = {31'b0, a < b};
          {7'h00, 3'd4}: res = a ^ b;
          {7'h00, 3'd5}: res = a >> b[4:0];
          {7'h20, 3'd5}: res = $signed(a) >>> b[4:0];
          {7'h00, 3'd6}: res = a | b;
          {7'h00, 3'd7}: res = a & b;
          {7'h20, 3'd7}: res = a & ~b;
          {7'h20, 3'd6}: res = a | ~b;
          {7'h20, 3'd4}: res = ~(a ^ b);
          {7'h05, 3'd4}: res = ($signed(a) < $signed(b)) ? a : b;
          {7'h05, 3'd5}: res = (a < b) ? a : b;
          {7'h05, 3'd6}: res = ($signed(a) < $signed(b)) ? b : a;
          {7'h05, 3'd7}: res = (a < b) ? b : a;
          {7'h30, 3'd1}: res = rotate(a, b[4:0]);
          {7'h30, 3'd5}: res = rotate(a, 32 - b[4:0]);
          default:       ok  = 1'b0;
        endcase
      end
      OP_IMM: begin
        case (f3)
          3'd0: res = a + imm;
          3'd2: res = {31'b0, $signed(a) < $signed(imm)};
          3'd3: res = {31'b0, a < imm};
          3'd4: res = a ^ imm;
          3'd6: res = a | imm;
          3'd7: res = a & imm;
          3'd1: begin
            if (f7 == 7'h00) begin
              res = a << sh;
            end else if (f7 == 7'h30 && sh == 5'd0) begin
              res = count_lead_zeros(a);
            end else if (f7 == 7'h30 && sh == 5'd1) begin
              res = count_trail_zeros(a);
            end else if (f7 == 7'h30 && sh == 5'd2) begin
              res = pop_count(a);
            end else if (f7 == 7'h30 && sh == 5'd4) begin
              res = {{24{a[7]}}, a[7:0]};
            end else if (f7 == 7'h30 && sh == 5'd5) begin
              res = {{16{a[15]}}, a[15:0]};
            end else begin
              ok = 1'b0;
            end
          end
          default: begin
            if (f7 == 7'h00) begin
              res = a >> sh;
            end else if (f7 == 7'h20) begin
              res = $signed(a) >>> sh;
            end else if (f7 == 7'h30) begin
              res = rotate(a, 32 - sh);
            end else if (f7 == 7'h34 && sh == 5'd24) begin
              res = {a[7:0], a[15:8], a[23:16], a[31:24]};
            end else if (f7 == 7'h14 && sh == 5'd7) begin
              res = or_combine(a);
            end else begin
              ok = 1'b0;
            end
          end
        endcase
      end
      BRANCH: begin
        is_br = 1'b1;
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = $signed(a) < $signed(b);
          3'd5:    taken = $signed(a) >= $signed(b);
          3'd6:    taken = a < b;
          3'd7:    taken = a >= b;
          default: ok    = 1'b0;
        endcase
      end
      default: ok = 1'b0;
    endcase
    e.wb.valid   = 1'b1;
    e.wb.illegal = ~ok;
    e.wb.rd      = (is_br || !ok) ? 5'd0 : instr[11:7];
    e.wb.result  = (is_br || !ok || e.wb.rd == 5'd0) ? '0 : res;
    if (is_br && ok) begin
      e.br.valid  = 1'b1;
      e.br.taken  = taken;
      e.br.target = pc_v + bimm;
    end
    return e;
  endfunction

  // ------------------------------------------------
  // Encoders, rs1 is x1 and rs2 is x2
  // ------------------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {imm, 5'd1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [2:0] f3);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  // ------------------------------------------------
  // Drive and check
  // ------------------------------------------------
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("ERR %0t: %s: got 0x%h, expected 0x%h", $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic issue(input logic [31:0] instr, input logic [31:0] pc_v,
                       input logic [31:0] a, input logic [31:0] b);
    exp_t e;
    @(posedge clk_i);
    valid_i    <= 1'b1;
    instr_i    <= instr;
    pc_i       <= pc_v;
    rs1_data_i <= a;
    rs2_data_i <= b;
    e     = predict(instr, pc_v, a, b);
    e.due = cycles + 2;
    exp_q.push_back(e);
  endtask

  task automatic idle();
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  // Output of a drive at edge k is due at the falling edge after k+2
  always @(negedge clk_i) begin : compare_outputs
    exp_t e;
    if (exp_q.size() != 0 && exp_q[0].due == cycles) begin
      e = exp_q.pop_front();
      check_value(wb.valid, e.wb.valid, "wb valid");
      check_value(wb.illegal, e.wb.illegal, "wb illegal");
      check_value(wb.rd, e.wb.rd, "wb rd");
      check_value(wb.result, e.wb.result, "wb result");
      check_value(br.valid, e.br.valid, "branch valid");
      check_value(br.taken, e.br.taken, "branch taken");
      check_value(br.target, e.br.target, "branch target");
    end else begin
      check_value(wb.valid, 1'b0, "wb valid with nothing issued");
      check_value(br.valid, 1'b0, "branch valid with nothing issued");
    end
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------------------------
  // Directed tests
  // ------------------------------------------------
  task automatic test_reset_state();
    repeat (3) idle();
    @(negedge clk_i);
    check_value(wb.valid, 1'b0, "wb valid after reset");
    check_value(br.valid, 1'b0, "branch valid after reset");
    check_value(br.taken, 1'b0, "branch taken after reset");
  endtask

  task automatic test_reg_reg();
    logic [9:0]  sel [10];
    logic [31:0] edges [3];
    sel = '{{7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd1}, {7'h00, 3'd2}, {7'h00, 3'd3},
            {7'h00, 3'd4}, {7'h00, 3'd5}, {7'h20, 3'd5}, {7'h00, 3'd6}, {7'h00, 3'd7}};
    edges = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
    for (int op = 0; op < 10; op++) begin
      for (int j = 0; j < 3; j++) begin
        issue(r_type(sel[op][9:3], sel[op][2:0], 5'(op + 1)), 32'h100,
              edges[j], edges[(j + 1) % 3]);
      end
      repeat (2) issue(r_type(sel[op][9:3], sel[op][2:0], 5'(op + 11)), 32'h100,
                       $random(seed), $random(seed));
    end
  endtask

  task automatic test_imm();
    logic [2:0]  f3s [6];
    logic [11:0] imms [3];
    logic [9:0]  shifts [3];
    f3s    = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    imms   = '{12'hfff, 12'h800, 12'h7ff};
    shifts = '{{7'h00, 3'd1}, {7'h00, 3'd5}, {7'h20, 3'd5}};
    for (int op = 0; op < 6; op++) begin
      for (int j = 0; j < 3; j++) begin
        issue(i_type(imms[j], f3s[op], 5'd3), 32'h200,
              (j == 0) ? 32'h8000_0000 : $random(seed), 0);
      end
      issue(i_type(12'($random(seed)), f3s[op], 5'd4), 32'h200, $random(seed), 0);
    end
    for (int op = 0; op < 3; op++) begin
      issue(i_type({shifts[op][9:3], 5'd0}, shifts[op][2:0], 5'd5), 32'h200, 32'h8000_f0f1, 0);
      issue(i_type({shifts[op][9:3], 5'd31}, shifts[op][2:0], 5'd5), 32'h200, 32'h8000_f0f1, 0);
      issue(i_type({shifts[op][9:3], 5'($random(seed))}, shifts[op][2:0], 5'd6), 32'h200,
            $random(seed), 0);
    end
    // Writes to x0 still report valid
    issue(i_type(12'h123, 3'd0, 5'd0), 32'h200, $random(seed), 0);
    issue(i_type(12'hf0f, 3'd4, 5'd0), 32'h200, $random(seed), 0);
  endtask

  task automatic test_branch();
    logic [2:0]  f3s [6];
    logic [31:0] as [5];
    logic [31:0] bs [5];
    logic [12:0] offs [5];
    logic [31:0] pcs [5];
    f3s  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    as   = '{32'd5, 32'hffff_ffff, 32'd1, 32'd1, 32'd2};
    bs   = '{32'd5, 32'd1, 32'hffff_ffff, 32'd2, 32'd1};
    offs = '{13'h0ffe, 13'h1ff4, 13'h0010, 13'h1000, 13'h0ffe};
    // Last case wraps past the top of the address space
    pcs  = '{32'h800, 32'h800, 32'h800, 32'h800, 32'hffff_fff0};
    for (int op = 0; op < 6; op++) begin
      for (int k = 0; k < 5; k++) begin
        issue(b_type(offs[k], f3s[op]), pcs[k], as[k], bs[k]);
      end
    end
  endtask

  task automatic test_zbb();
    logic [9:0] sel [9];
    logic [4:0] unary [5];
    sel   = '{{7'h20, 3'd7}, {7'h20, 3'd6}, {7'h20, 3'd4}, {7'h05, 3'd4}, {7'h05, 3'd6},
              {7'h05, 3'd5}, {7'h05, 3'd7}, {7'h30, 3'd1}, {7'h30, 3'd5}};
    unary = '{5'd0, 5'd1, 5'd2, 5'd4, 5'd5};
    for (int op = 0; op < 9; op++) begin
      issue(r_type(sel[op][9:3], sel[op][2:0], 5'd7), 32'h300, $random(seed), $random(seed));
      issue(r_type(sel[op][9:3], sel[op][2:0], 5'd7), 32'h300, 32'h8000_0001, 32'hffff_fff0);
    end
    // Rotates by zero
    issue(r_type(7'h30, 3'd1, 5'd8), 32'h300, 32'hdead_beef, 32'h0000_0020);
    issue(r_type(7'h30, 3'd5, 5'd8), 32'h300, 32'hdead_beef, 32'h0000_0000);
    issue(i_type({7'h30, 5'd0}, 3'd5, 5'd8), 32'h300, 32'h1234_5678, 0);
    issue(i_type({7'h30, 5'($random(seed))}, 3'd5, 5'd8), 32'h300, $random(seed), 0);
    for (int u = 0; u < 5; u++) begin
      issue(i_type({7'h30, unary[u]}, 3'd1, 5'd9), 32'h300, 32'h0, 0);
      issue(i_type({7'h30, unary[u]}, 3'd1, 5'd9), 32'h300, $random(seed), 0);
    end
    repeat (2) issue(i_type({7'h34, 5'd24}, 3'd5, 5'd10), 32'h300, $random(seed), 0);
    issue(i_type({7'h14, 5'd7}, 3'd5, 5'd10), 32'h300, $random(seed), 0);
    issue(i_type({7'h14, 5'd7}, 3'd5, 5'd10), 32'h300, 32'h00ff_0100, 0);
  endtask

  task automatic test_illegal();
    issue(r_type(7'h00, 3'd0, 5'd12), 32'h400, $random(seed), $random(seed));
    issue(32'h0020_a283, 32'h404, $random(seed), $random(seed));
    issue(r_type(7'h20, 3'd0, 5'd12), 32'h408, $random(seed), $random(seed));
    // Multiply encoding is not supported
    issue(r_type(7'h01, 3'd0, 5'd12), 32'h40c, $random(seed), $random(seed));
    issue(i_type(12'h05a, 3'd0, 5'd13), 32'h410, $random(seed), 0);
    issue(i_type({7'h20, 5'd3}, 3'd1, 5'd13), 32'h414, $random(seed), 0);
    issue(b_type(13'h0010, 3'd0), 32'h418, 32'd9, 32'd9);
    issue(b_type(13'h0010, 3'd2), 32'h41c, 32'd9, 32'd9);
    issue(32'hffff_ffff, 32'h420, $random(seed), $random(seed));
    issue(r_type(7'h00, 3'd4, 5'd14), 32'h424, $random(seed), $random(seed));
  endtask

  initial begin
    rst_n_i    = 1'b0;
    valid_i    = 1'b0;
    instr_i    = '0;
    pc_i       = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset_state();
    test_reg_reg();
    test_imm();
    test_branch();
    test_zbb();
    test_illegal();
    idle();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    if (errors == 0 && dut.i_assertions.failures == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Assertions failed %0d times during the run", dut.i_assertions.failures);
      $display("TEST FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

//--- tb_int_exu_assertions.sv
`default_nettype none

module tb_int_exu_assertions
  import exu_pkg::*;
(
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    valid_i,
  input wb_t     wb_i,
  input branch_t branch_i
);

  // Number of failed assertions over the run
  int unsigned failures = 0;

  // ------------------------------------------------
  // Reset and output consistency
  // ------------------------------------------------
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !wb_i.valid && !branch_i.valid && !branch_i.taken)
    else begin
      failures = failures + 1;
      $error("outputs active while reset is held");
    end

  branch_has_wb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    branch_i.valid |-> wb_i.valid)
    else begin
      failures = failures + 1;
      $error("branch valid without writeback valid");
    end

  // Bad encodings carry no data and resolve no branch
  illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_i.illegal |-> wb_i.result == '0 && !branch_i.valid)
    else begin
      failures = failures + 1;
      $error("illegal instruction with result or branch");
    end

  // Two stage pipeline
  latency_two: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> ##2 wb_i.valid)
    else begin
      failures = failures + 1;
      $error("accepted instruction not written back two cycles later");
    end

endmodule

bind int_exu_top tb_int_exu_assertions i_assertions (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .valid_i (valid_i),
  .wb_i    (wb_o),
  .branch_i(branch_o)
);

`default_nettype wire

//--- verilog.f
exu_pkg.sv
exu_decoder.sv
alu.sv
exu_result.sv
int_exu_top.sv
tb_int_exu_assertions.sv
tb_int_exu.sv
